/* lc4_alu.sv */
// ====================
// Execute-stage ALU and address adder
// NZP of the result
// ====================
module lc4_alu (
  input  lc4_isa_pkg::alu_op_e i_op,
  input  lc4_isa_pkg::word_t   i_pc,
  input  lc4_isa_pkg::word_t   i_a,      // rs after bypass
  input  lc4_isa_pkg::word_t   i_b,      // rt after bypass
  input  lc4_isa_pkg::word_t   i_imm,    // Already sign-extended
  output lc4_isa_pkg::word_t   o_result,
  output lc4_isa_pkg::nzp_t    o_nzp
);
  import lc4_isa_pkg::*;

  word_t sum_ab;
  word_t diff_ab;
  word_t sum_imm;
  word_t br_target;

  assign sum_ab    = i_a + i_b;
  assign diff_ab   = i_a - i_b;
  assign sum_imm   = i_a + i_imm;            // ADD imm5 and LDR/STR address
  assign br_target = i_pc + 16'd1 + i_imm;   // Relative to the next PC

  always_comb begin
    case (i_op)
      ALU_ADD:     o_result = sum_ab;
      ALU_SUB:     o_result = diff_ab;
      ALU_AND:     o_result = i_a & i_b;
      ALU_ADDI:    o_result = sum_imm;
      ALU_CONST:   o_result = i_imm;
      ALU_ADDR:    o_result = sum_imm;
      ALU_ADDR_PC: o_result = br_target;
      default:     o_result = '0;
    endcase
  end

  // Flags go with the instruction, used only when it sets NZP
  assign o_nzp = nzp_of(o_result);

endmodule

/* lc4_decoder.sv */
// ====================
// LC4 instruction decoder
// ====================
`include "lc4_defs.svh"

module lc4_decoder (
  input  lc4_isa_pkg::word_t    i_insn,
  output lc4_isa_pkg::reg_sel_t o_rs,
  output lc4_isa_pkg::reg_sel_t o_rt,
  output lc4_isa_pkg::reg_sel_t o_rd,
  output lc4_isa_pkg::word_t    o_imm,
  output lc4_isa_pkg::ctrl_t    o_ctrl
);
  import lc4_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] sub_op;     // Bits 5:3 of ARITH and LOGIC
  word_t      imm5;
  word_t      imm6;
  word_t      imm9;

  assign opcode = opcode_e'(i_insn[15:12]);
  assign sub_op = i_insn[5:3];

  // Sign extension of each immediate field
  assign imm5 = {{(`LC4_WORD_W-`LC4_IMM5_W){i_insn[`LC4_IMM5_W-1]}}, i_insn[`LC4_IMM5_W-1:0]};
  assign imm6 = {{(`LC4_WORD_W-`LC4_IMM6_W){i_insn[`LC4_IMM6_W-1]}}, i_insn[`LC4_IMM6_W-1:0]};
  assign imm9 = {{(`LC4_WORD_W-`LC4_IMM9_W){i_insn[`LC4_IMM9_W-1]}}, i_insn[`LC4_IMM9_W-1:0]};

  always_comb begin
    o_ctrl = '0;            // Anything unmatched stays a NOP
    o_rs   = i_insn[8:6];
    o_rt   = i_insn[2:0];
    o_rd   = i_insn[11:9];
    o_imm  = imm5;
    case (opcode)
      OP_BR: begin
        if (i_insn[11:9] != 3'b000) begin   // nzp 000 is the NOP
          o_ctrl.is_branch  = 1'b1;
          o_ctrl.branch_nzp = i_insn[11:9];
          o_ctrl.alu_op     = ALU_ADDR_PC;
          o_imm             = imm9;
        end
      end
      OP_ARITH: begin
        if (i_insn[5]) begin                 // ADD rd, rs, imm5
          o_ctrl = '{rs_re: 1'b1, regfile_we: 1'b1, nzp_we: 1'b1, alu_op: ALU_ADDI, default: '0};
        end else if (sub_op == 3'b000 || sub_op == 3'b010) begin
          o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, regfile_we: 1'b1, nzp_we: 1'b1,
                     alu_op: (sub_op == 3'b000) ? ALU_ADD : ALU_SUB, default: '0};
        end
      end
      OP_LOGIC: begin
        if (i_insn[5:3] == 3'b000) begin     // Register AND only
          o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, regfile_we: 1'b1, nzp_we: 1'b1,
                     alu_op: ALU_AND, default: '0};
        end
      end
      OP_LDR: begin
        o_ctrl = '{rs_re: 1'b1, regfile_we: 1'b1, nzp_we: 1'b1, is_load: 1'b1,
                   alu_op: ALU_ADDR, default: '0};
        o_imm  = imm6;
      end
      OP_STR: begin
        o_rt   = i_insn[11:9];               // Data register sits in the rd field
        o_ctrl = '{rs_re: 1'b1, rt_re: 1'b1, is_store: 1'b1, alu_op: ALU_ADDR, default: '0};
        o_imm  = imm6;
      end
      OP_CONST: begin
        o_ctrl = '{regfile_we: 1'b1, nzp_we: 1'b1, alu_op: ALU_CONST, default: '0};
        o_imm  = imm9;
      end
      default: ;
    endcase
  end

  // The memory stage drives one access per instruction
  always_comb begin
    a_ld_st_excl: assert (!(o_ctrl.is_load && o_ctrl.is_store))
      else $error("decoder flags both load and store for %h", i_insn);
  end

endmodule

/* lc4_defs.svh */
// ====================
// LC4 width, register count and reset macros
// Immediate field widths of the kept instructions
// ====================
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// Machine word
`define LC4_WORD_W    16
`define LC4_OPC_W     4       // Opcode field in bits 15:12

// Register file
`define LC4_NREGS     8

// Fetch starts here after reset
`define LC4_RESET_PC  16'h8200

// Immediate fields, all sign-extended
`define LC4_IMM5_W    5       // ADD immediate
`define LC4_IMM6_W    6       // LDR/STR offset
`define LC4_IMM9_W    9       // CONST value and BR offset

`endif

/* lc4_hazard_unit.sv */
// ====================
// Load-use stall, branch flush
// Execute operand bypass select
// ====================
module lc4_hazard_unit (
  input  lc4_pipe_pkg::dx_t      i_dx,
  input  lc4_pipe_pkg::xm_t      i_xm,
  input  lc4_isa_pkg::reg_sel_t  i_mw_rd,
  input  logic                   i_mw_we,     // Qualified with the W valid bit
  input  lc4_isa_pkg::reg_sel_t  i_d_rs,
  input  lc4_isa_pkg::reg_sel_t  i_d_rt,
  input  lc4_isa_pkg::ctrl_t     i_d_ctrl,
  input  logic                   i_branch_taken,
  output logic                   o_stall,
  output logic                   o_flush,
  output lc4_pipe_pkg::fwd_sel_e o_fwd_a,
  output lc4_pipe_pkg::fwd_sel_e o_fwd_b
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  logic x_load;
  logic m_writes;

  // Newest older writer wins, M before W
  function automatic fwd_sel_e pick_src(reg_sel_t sel, logic re);
    fwd_sel_e src;
    src = FWD_REG;
    if (re && m_writes && i_xm.rd == sel) begin
      src = FWD_FROM_M;
    end else if (re && i_mw_we && i_mw_rd == sel) begin
      src = FWD_FROM_W;
    end
    return src;
  endfunction

  assign x_load   = i_dx.valid && i_dx.ctrl.is_load;
  assign m_writes = i_xm.valid && i_xm.ctrl.regfile_we;

  // Loaded word is ready in W only, a BR also waits for its NZP
  assign o_stall = x_load && ((i_d_ctrl.rs_re && i_d_rs == i_dx.rd) ||
                              (i_d_ctrl.rt_re && i_d_rt == i_dx.rd) ||
                              i_d_ctrl.is_branch);
  assign o_flush = i_branch_taken;     // Squash F and D

  always_comb begin
    o_fwd_a = pick_src(i_dx.rs, i_dx.ctrl.rs_re);
    o_fwd_b = pick_src(i_dx.rt, i_dx.ctrl.rt_re);
  end

  // A taken branch in X is never a load, so the two cannot meet
  always_comb begin
    a_stall_flush: assert (!(o_stall && o_flush))
      else $error("stall and flush raised in the same cycle");
  end

endmodule

/* lc4_isa_pkg.sv */
// ====================
// Instruction-set types: words, selects, NZP
// Opcode and ALU enums, decoded control struct
// ====================
`include "lc4_defs.svh"

package lc4_isa_pkg;

  typedef logic [`LC4_WORD_W-1:0] word_t;               // Data or address word
  typedef logic [$clog2(`LC4_NREGS)-1:0] reg_sel_t;     // Register index
  typedef logic [2:0] nzp_t;                            // {N, Z, P}

  // Top four bits of the instruction
  typedef enum logic [`LC4_OPC_W-1:0] {
    OP_BR    = 4'b0000,
    OP_ARITH = 4'b0001,
    OP_LOGIC = 4'b0101,
    OP_LDR   = 4'b0110,
    OP_STR   = 4'b0111,
    OP_CONST = 4'b1001
  } opcode_e;

  // ALU function, ADD is zero so a cleared ctrl_t is harmless
  typedef enum logic [2:0] {
    ALU_ADD     = 3'd0,
    ALU_SUB     = 3'd1,
    ALU_AND     = 3'd2,
    ALU_ADDI    = 3'd3,
    ALU_CONST   = 3'd4,
    ALU_ADDR    = 3'd5,   // Base register plus offset
    ALU_ADDR_PC = 3'd6    // Branch target, PC + 1 + offset
  } alu_op_e;

  // Decoded control, travels down the pipe with the instruction
  typedef struct packed {
    logic    rs_re;
    logic    rt_re;
    logic    regfile_we;
    logic    nzp_we;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    nzp_t    branch_nzp;  // Condition bits of a BR
    alu_op_e alu_op;
  } ctrl_t;

  // Condition codes of a result word
  function automatic nzp_t nzp_of(word_t w);
    logic neg;
    logic zero;
    neg  = w[`LC4_WORD_W-1];
    zero = (w == '0);
    nzp_of = {neg, zero, !neg && !zero};
  endfunction

endpackage

/* lc4_pipe_pkg.sv */
// ====================
// Pipeline register structs, bypass select
// Writeback trace record
// ====================
package lc4_pipe_pkg;

  import lc4_isa_pkg::*;

  // F/D, bubble is all zero which decodes as NOP
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } fd_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    reg_sel_t rs;
    reg_sel_t rt;
    reg_sel_t rd;
    word_t    rs_data;    // Register file values read in decode
    word_t    rt_data;
    ctrl_t    ctrl;
    word_t    imm;
  } dx_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    reg_sel_t rd;
    ctrl_t    ctrl;
    word_t    alu_result; // Also the memory address of LDR/STR
    word_t    store_data;
    nzp_t     nzp;        // ALU flags, not valid for a load
  } xm_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    reg_sel_t rd;
    ctrl_t    ctrl;
    word_t    result;     // Loaded word or ALU result
    word_t    dmem_addr;
    word_t    store_data;
  } mw_t;

  // Where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_FROM_M = 2'd1,
    FWD_FROM_W = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    logic     regfile_we;
    reg_sel_t wsel;
    word_t    wdata;
    logic     nzp_we;
    nzp_t     nzp;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_data;
  } wb_trace_t;

endpackage

/* lc4_processor.sv */
// ====================
// Five-stage LC4 pipeline top level
// PC, stage registers, bypass, NZP, trace
// ====================
`include "lc4_defs.svh"

module lc4_processor (
  input  logic                    gwe,
  input  logic                    i_rst,
  output lc4_isa_pkg::word_t      o_cur_pc,
  input  lc4_isa_pkg::word_t      i_cur_insn,
  output lc4_isa_pkg::word_t      o_dmem_addr,
  input  lc4_isa_pkg::word_t      i_dmem_rdata,
  output logic                    o_dmem_we,
  output lc4_isa_pkg::word_t      o_dmem_wdata,
  output lc4_pipe_pkg::wb_trace_t o_wb
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  word_t    pc_q;
  fd_t      fd_q;
  dx_t      dx_q;
  xm_t      xm_q;
  mw_t      mw_q;
  nzp_t     nzp_q;        // Architected NZP, written at W
  reg_sel_t d_rs, d_rt, d_rd;
  word_t    d_imm, d_rs_data, d_rt_data;
  ctrl_t    d_ctrl;
  logic     stall, flush, branch_taken;
  fwd_sel_e fwd_a, fwd_b;
  word_t    x_a, x_b, x_result;
  nzp_t     x_nzp, br_nzp, w_nzp;
  word_t    m_addr;
  logic     w_we;

  // Operand mux, one per execute input
  function automatic word_t bypass(fwd_sel_e sel, word_t reg_val);
    case (sel)
      FWD_FROM_M: return xm_q.alu_result;
      FWD_FROM_W: return mw_q.result;
      default:    return reg_val;
    endcase
  endfunction

  // Fetch
  assign o_cur_pc = pc_q;

  always_ff @(posedge gwe) begin
    if (i_rst)       pc_q <= `LC4_RESET_PC;
    else if (flush)  pc_q <= x_result;       // Branch target from the ALU
    else if (!stall) pc_q <= pc_q + 16'd1;
  end

  always_ff @(posedge gwe) begin
    if (i_rst || flush) begin
      fd_q <= '0;                            // Zero insn decodes as NOP
    end else if (!stall) begin
      fd_q <= '{valid: 1'b1, pc: pc_q, insn: i_cur_insn};
    end
  end

  // Decode and register read
  lc4_decoder lc4_decoder_inst (
    .i_insn (fd_q.insn),
    .o_rs   (d_rs),
    .o_rt   (d_rt),
    .o_rd   (d_rd),
    .o_imm  (d_imm),
    .o_ctrl (d_ctrl)
  );

  lc4_regfile lc4_regfile_inst (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_rs      (d_rs),
    .i_rt      (d_rt),
    .o_rs_data (d_rs_data),
    .o_rt_data (d_rt_data),
    .i_rd      (mw_q.rd),
    .i_wdata   (mw_q.result),
    .i_we      (w_we)
  );

  lc4_hazard_unit lc4_hazard_unit_inst (
    .i_dx           (dx_q),
    .i_xm           (xm_q),
    .i_mw_rd        (mw_q.rd),
    .i_mw_we        (w_we),
    .i_d_rs         (d_rs),
    .i_d_rt         (d_rt),
    .i_d_ctrl       (d_ctrl),
    .i_branch_taken (branch_taken),
    .o_stall        (stall),
    .o_flush        (flush),
    .o_fwd_a        (fwd_a),
    .o_fwd_b        (fwd_b)
  );

  always_ff @(posedge gwe) begin
    if (i_rst || stall || flush) begin
      dx_q <= '0;                            // Bubble into execute
    end else begin
      dx_q <= '{valid: fd_q.valid, pc: fd_q.pc, insn: fd_q.insn,
                rs: d_rs, rt: d_rt, rd: d_rd,
                rs_data: d_rs_data, rt_data: d_rt_data,
                ctrl: d_ctrl, imm: d_imm};
    end
  end

  // Execute
  always_comb begin
    x_a = bypass(fwd_a, dx_q.rs_data);
    x_b = bypass(fwd_b, dx_q.rt_data);
  end

  lc4_alu lc4_alu_inst (
    .i_op     (dx_q.ctrl.alu_op),
    .i_pc     (dx_q.pc),
    .i_a      (x_a),
    .i_b      (x_b),
    .i_imm    (dx_q.imm),
    .o_result (x_result),
    .o_nzp    (x_nzp)
  );

  // Newest older NZP, M then W then the register
  always_comb begin
    if (xm_q.valid && xm_q.ctrl.nzp_we)      br_nzp = xm_q.nzp;
    else if (mw_q.valid && mw_q.ctrl.nzp_we) br_nzp = w_nzp;
    else                                     br_nzp = nzp_q;
  end

  assign branch_taken = dx_q.valid && dx_q.ctrl.is_branch &&
                        |(dx_q.ctrl.branch_nzp & br_nzp);

  always_ff @(posedge gwe) begin
    if (i_rst) xm_q <= '0;
    else       xm_q <= '{valid: dx_q.valid, pc: dx_q.pc, insn: dx_q.insn, rd: dx_q.rd,
                         ctrl: dx_q.ctrl, alu_result: x_result, store_data: x_b,
                         nzp: x_nzp};
  end

  // Memory
  assign m_addr       = (xm_q.valid && (xm_q.ctrl.is_load || xm_q.ctrl.is_store)) ?
                        xm_q.alu_result : '0;   // Zero for non-memory insns
  assign o_dmem_addr  = m_addr;
  assign o_dmem_we    = xm_q.valid && xm_q.ctrl.is_store;
  assign o_dmem_wdata = o_dmem_we ? xm_q.store_data : '0;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      mw_q <= '0;
    end else begin
      mw_q <= '{valid: xm_q.valid, pc: xm_q.pc, insn: xm_q.insn, rd: xm_q.rd,
                ctrl: xm_q.ctrl,
                result: xm_q.ctrl.is_load ? i_dmem_rdata : xm_q.alu_result,
                dmem_addr: m_addr, store_data: o_dmem_wdata};
    end
  end

  // Writeback
  assign w_we  = mw_q.valid && mw_q.ctrl.regfile_we;
  assign w_nzp = nzp_of(mw_q.result);       // Loads take flags from the loaded word

  always_ff @(posedge gwe) begin
    if (i_rst)                               nzp_q <= '0;
    else if (mw_q.valid && mw_q.ctrl.nzp_we) nzp_q <= w_nzp;
  end

  always_comb begin
    o_wb            = '0;
    o_wb.valid      = mw_q.valid;
    o_wb.pc         = mw_q.pc;
    o_wb.insn       = mw_q.insn;
    o_wb.regfile_we = w_we;
    o_wb.wsel       = mw_q.rd;
    o_wb.wdata      = w_we ? mw_q.result : '0;
    o_wb.nzp_we     = mw_q.valid && mw_q.ctrl.nzp_we;
    o_wb.nzp        = o_wb.nzp_we ? w_nzp : '0;
    o_wb.dmem_we    = mw_q.valid && mw_q.ctrl.is_store;
    o_wb.dmem_addr  = mw_q.dmem_addr;
    o_wb.dmem_data  = mw_q.ctrl.is_load ? mw_q.result : mw_q.store_data;
  end

  // Load-use stall keeps a load in M away from X operands and BR flags
  a_load_in_m: assert property (@(posedge gwe) disable iff (i_rst)
    (xm_q.valid && xm_q.ctrl.is_load) |->
      !(fwd_a == FWD_FROM_M || fwd_b == FWD_FROM_M || (dx_q.valid && dx_q.ctrl.is_branch)))
    else $error("load in the memory stage feeds execute through bypass or NZP");

endmodule

/* lc4_regfile.sv */
// ====================
// Eight-entry register file, two reads
// Write-through on a same-cycle read
// ====================
`include "lc4_defs.svh"

module lc4_regfile (
  input  logic                  gwe,
  input  logic                  i_rst,
  input  lc4_isa_pkg::reg_sel_t i_rs,
  input  lc4_isa_pkg::reg_sel_t i_rt,
  output lc4_isa_pkg::word_t    o_rs_data,
  output lc4_isa_pkg::word_t    o_rt_data,
  input  lc4_isa_pkg::reg_sel_t i_rd,
  input  lc4_isa_pkg::word_t    i_wdata,
  input  logic                  i_we
);
  import lc4_isa_pkg::*;

  word_t regs [`LC4_NREGS];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < `LC4_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // Decode sees the value writeback is storing this cycle
  assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_lc4_processor
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module "$TOP" -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "^Everything OK$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

/* tb_lc4_processor.sv */
// ====================
// Testbench for the LC4 pipeline
// Memory models, program and retirement tables
// ====================
`include "lc4_defs.svh"

module tb_lc4_processor;
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  localparam int N_PROG         = 20;
  localparam int N_RET          = 18;
  localparam int RETIRE_TIMEOUT = 50;   // Cycles allowed per retirement
  localparam int QUIET_CYCLES   = 20;

  // One expected retirement, in program order
  typedef struct packed {
    logic [15:0] pc;
    logic        rf_we;
    logic [2:0]  wsel;
    logic [15:0] wdata;
    logic [2:0]  nzp;      // Zero when the insn sets no flags
    logic        dmem_we;
    logic [15:0] daddr;    // Zero for non-memory insns
    logic [15:0] ddata;
  } retire_t;

  // Program, word i sits at 16'h8200 + i
  localparam logic [15:0] PROG [N_PROG] = '{
    16'h9205,   // CONST R1, 5
    16'h95FD,   // CONST R2, -3
    16'h1642,   // ADD   R3, R1, R2   M and W bypass
    16'h18D1,   // SUB   R4, R3, R1
    16'h5B01,   // AND   R5, R4, R1
    16'h1D7B,   // ADD   R6, R5, #-5  Result zero
    16'h9E20,   // CONST R7, 0x20
    16'h79C1,   // STR   R4, R7, #1
    16'h61C1,   // LDR   R0, R7, #1
    16'h1200,   // ADD   R1, R0, R0   Load-use
    16'h65C1,   // LDR   R2, R7, #1
    16'h0802,   // BRn   +2           Right behind a load, taken
    16'h9655,   // CONST R3, 0x55     Squashed
    16'h9666,   // CONST R3, 0x66     Squashed
    16'h17A7,   // ADD   R3, R6, #7
    16'h0401,   // BRz   +1           Not taken
    16'h9A1F,   // CONST R5, 0x1F
    16'h0000,   // BR 000, NOP
    16'h1D43,   // ADD   R6, R5, R3
    16'h7DC2    // STR   R6, R7, #2
  };

  // pc, rf_we, wsel, wdata, nzp, dmem_we, daddr, ddata
  localparam retire_t EXPECTED [N_RET] = '{
    '{16'h8200, 1'b1, 3'd1, 16'h0005, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8201, 1'b1, 3'd2, 16'hFFFD, 3'b100, 1'b0, 16'h0000, 16'h0000},
    '{16'h8202, 1'b1, 3'd3, 16'h0002, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8203, 1'b1, 3'd4, 16'hFFFD, 3'b100, 1'b0, 16'h0000, 16'h0000},
    '{16'h8204, 1'b1, 3'd5, 16'h0005, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8205, 1'b1, 3'd6, 16'h0000, 3'b010, 1'b0, 16'h0000, 16'h0000},
    '{16'h8206, 1'b1, 3'd7, 16'h0020, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8207, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b1, 16'h0021, 16'hFFFD},
    '{16'h8208, 1'b1, 3'd0, 16'hFFFD, 3'b100, 1'b0, 16'h0021, 16'hFFFD},
    '{16'h8209, 1'b1, 3'd1, 16'hFFFA, 3'b100, 1'b0, 16'h0000, 16'h0000},
    '{16'h820A, 1'b1, 3'd2, 16'hFFFD, 3'b100, 1'b0, 16'h0021, 16'hFFFD},
    '{16'h820B, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000},
    '{16'h820E, 1'b1, 3'd3, 16'h0007, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h820F, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000},
    '{16'h8210, 1'b1, 3'd5, 16'h001F, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8211, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b0, 16'h0000, 16'h0000},
    '{16'h8212, 1'b1, 3'd6, 16'h0026, 3'b001, 1'b0, 16'h0000, 16'h0000},
    '{16'h8213, 1'b0, 3'd0, 16'h0000, 3'b000, 1'b1, 16'h0022, 16'h0026}
  };

  logic      gwe;
  logic      i_rst;
  word_t     cur_pc, cur_insn;
  word_t     dmem_addr, dmem_rdata, dmem_wdata;
  logic      dmem_we;
  wb_trace_t wb;
  word_t     dmem [256];     // Small data memory, low address byte

  lc4_processor lc4_processor_inst (
    .gwe          (gwe),
    .i_rst        (i_rst),
    .o_cur_pc     (cur_pc),
    .i_cur_insn   (cur_insn),
    .o_dmem_addr  (dmem_addr),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .o_wb         (wb)
  );

  // Instruction ROM, anything outside the program is a NOP
  function automatic word_t fetch_insn(input word_t pc);
    word_t offset;
    offset = pc - `LC4_RESET_PC;
    if (offset < 16'(N_PROG)) return PROG[int'(offset)];
    return 16'h0000;
  endfunction

  function automatic string field_name(input int idx, input string field);
    return $sformatf("retire %0d %s", idx, field);
  endfunction

  assign cur_insn   = fetch_insn(cur_pc);      // Same-cycle answer
  assign dmem_rdata = dmem[dmem_addr[7:0]];

  // Data memory writes on the rising edge
  always @(posedge gwe) begin
    if (i_rst) begin
      for (int a = 0; a < 256; a++) dmem[a] <= '0;
    end else if (dmem_we) begin
      dmem[dmem_addr[7:0]] <= dmem_wdata;
    end
  end

  initial begin
    gwe = 1'b0;
    forever #20 gwe = ~gwe;
  end

  task automatic stop_with_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Next valid retirement, sampled at the falling edge
  task automatic wait_for_retire(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge gwe);
      cycles++;
    end while (!wb.valid && cycles < RETIRE_TIMEOUT);
    if (!wb.valid) begin
      $display("Retirement %0d did not appear within %0d cycles", idx, RETIRE_TIMEOUT);
      stop_with_failure();
    end
  endtask

  initial begin
    retire_t want;
    i_rst = 1'b1;
    repeat (10) @(negedge gwe);
    i_rst = 1'b0;

    for (int i = 0; i < N_RET; i++) begin
      wait_for_retire(i);
      want = EXPECTED[i];
      check_equal(field_name(i, "pc"), want.pc, wb.pc);             // Program order
      check_equal(field_name(i, "insn"), fetch_insn(want.pc), wb.insn);
      check_equal(field_name(i, "regfile_we"), 16'(want.rf_we), 16'(wb.regfile_we));
      if (want.rf_we) begin
        check_equal(field_name(i, "wsel"), 16'(want.wsel), 16'(wb.wsel));
        check_equal(field_name(i, "wdata"), want.wdata, wb.wdata);
      end
      check_equal(field_name(i, "nzp"), 16'(want.nzp), 16'(wb.nzp));
      check_equal(field_name(i, "nzp_we"), 16'(want.nzp != '0), 16'(wb.nzp_we));
      check_equal(field_name(i, "dmem_we"), 16'(want.dmem_we), 16'(wb.dmem_we));
      check_equal(field_name(i, "dmem_addr"), want.daddr, wb.dmem_addr);
      if (want.daddr != '0) begin                                   // Loads and stores
        check_equal(field_name(i, "dmem_data"), want.ddata, wb.dmem_data);
      end
    end

    // Only NOPs may retire past the program
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      @(negedge gwe);
      if (wb.valid && (wb.regfile_we || wb.dmem_we)) begin
        $display("Unexpected retirement with a write at pc %h", wb.pc);
        stop_with_failure();
      end
    end

    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_hazard_unit.sv
lc4_processor.sv
tb_lc4_processor.sv
